/* hw/vendPkg.sv */
`default_nettype none

package vendPkg;

    localparam int NumSlots = 9;                       // A1..C3 as index 0..8

    typedef logic [8:0]  moneyT;                       // cents, up to 5.11
    typedef logic [13:0] figureT;                      // room for 9999 on four digits
    typedef logic [3:0]  slotIdxT;
    typedef logic [3:0]  digitT;                       // one bcd digit
    typedef logic [7:0]  segT;                         // active low, bit 0 is the point

    typedef moneyT [NumSlots-1:0] priceListT;          // index 8 sits in the top bits

    typedef enum logic [2:0] {
        coinNone,
        coinNickel,
        coinDime,
        coinQuarter,
        coinDollar,
        coinFive
    } coinT;

    typedef struct packed {
        logic [NumSlots-1:0] ready;                    // enough credit for this slot
        logic [NumSlots-1:0] soldOut;                  // price of zero
        logic [NumSlots-1:0] dispensed;                // bought since last cancel
    } slotLedsT;

    typedef struct packed {
        figureT figure;                                // magnitude in cents or plain count
        logic   showPoint;                             // point after the hundreds digit
        logic   negative;                              // shortfall, minus on the left digit
    } dispWordT;

    localparam segT SegDigits [10] = '{
        8'b10000001, 8'b11110011, 8'b01001001, 8'b01100001, 8'b00110011,
        8'b00100101, 8'b00000101, 8'b11110001, 8'b00000001, 8'b00100001
    };
    localparam segT SegMinus = 8'b01111111;            // middle bar only

    function automatic moneyT coinCents(coinT c);
        case (c)
            coinNickel:  return moneyT'(5);
            coinDime:    return moneyT'(10);
            coinQuarter: return moneyT'(25);
            coinDollar:  return moneyT'(100);
            coinFive:    return moneyT'(500);
            default:     return '0;                    // idle, no coin
        endcase
    endfunction

endpackage

`default_nettype wire

/* hw/priceTable.sv */
`timescale 1ns/1ps
`default_nettype none

module priceTable
    import vendPkg::*;
#(
    parameter priceListT PriceList = '0                // all sold out unless overridden
) (
    input  slotIdxT             slotIdx,
    input  moneyT               credit,
    output moneyT               selPrice,
    output logic [NumSlots-1:0] ready,
    output logic [NumSlots-1:0] soldOut
);

    // price of the addressed slot, indices past C3 read as zero
    always_comb begin
        if (slotIdx < slotIdxT'(NumSlots)) begin
            selPrice = PriceList[slotIdx];
        end else begin
            selPrice = '0;
        end
    end

    // one comparator per slot drives the green and red LEDs
    always_comb begin
        for (int i = 0; i < NumSlots; i++) begin
            soldOut[i] = (PriceList[i] == '0);                  // zero price marks empty slot
            ready[i]   = !soldOut[i] && (credit >= PriceList[i]); // green once credit covers it
        end
    end

endmodule

`default_nettype wire

/* hw/creditLedger.sv */
`timescale 1ns/1ps
`default_nettype none

module creditLedger
    import vendPkg::*;
#(
    parameter moneyT MaxCredit = '1
) (
    input  logic                A1,
    input  logic                A2,
    input  coinT                coin,
    input  logic                selectStrobe,
    input  slotIdxT             slotIdx,
    input  logic                cancel,
    input  moneyT               selPrice,
    output moneyT               credit,
    output logic [NumSlots-1:0] dispensed,
    output dispWordT            dispWord,
    output logic                figureStrobe
);

    logic [9:0]          coinSum;        // one extra bit so a five on top of credit cannot wrap
    logic                coinOk;
    logic                canBuy;
    moneyT               creditNext;
    logic [NumSlots-1:0] dispensedNext;
    logic                figureLoad;     // this cycle produces a new figure
    dispWordT            wordNext;

    function automatic dispWordT makeWord(moneyT value, logic point, logic neg);
        return '{figure: figureT'(value), showPoint: point, negative: neg};
    endfunction

    assign coinSum = {1'b0, credit} + {1'b0, coinCents(coin)};
    assign coinOk  = (coinSum <= {1'b0, MaxCredit});
    assign canBuy  = (selPrice != '0) && (credit >= selPrice);  // sold-out slot never sells

    // coin wins over select and select over cancel
    always_comb begin
        creditNext    = credit;
        dispensedNext = dispensed;
        figureLoad    = 1'b0;
        wordNext      = makeWord('0, 1'b0, 1'b0);
        if (coin != coinNone) begin
            if (coinOk) begin                                  // rejected coin changes nothing
                creditNext = coinSum[8:0];
                figureLoad = 1'b1;
                wordNext   = makeWord(coinSum[8:0], 1'b1, 1'b0);
            end
        end else if (selectStrobe) begin
            figureLoad = 1'b1;
            if (credit == '0) begin
                wordNext = makeWord(selPrice, 1'b1, 1'b0);      // price check only
            end else if (canBuy) begin
                creditNext             = '0;                   // change goes back out
                dispensedNext[slotIdx] = 1'b1;
                wordNext               = makeWord(credit - selPrice, 1'b1, 1'b0);
            end else if (credit < selPrice) begin
                wordNext = makeWord(selPrice - credit, 1'b1, 1'b1); // still owed
            end else begin
                wordNext = makeWord(selPrice, 1'b1, 1'b0);      // sold-out slot shows 0.00
            end
        end else if (cancel) begin
            creditNext    = '0;
            dispensedNext = '0;
            figureLoad    = 1'b1;
            wordNext      = makeWord('0, 1'b0, 1'b0);           // plain 0000
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit       <= '0;
            dispensed    <= '0;
            figureStrobe <= 1'b0;
        end else begin
            credit       <= creditNext;
            dispensed    <= dispensedNext;
            figureStrobe <= figureLoad;                         // one cycle after the input strobe
        end
    end

    // outgoing figure held until the next result
    always_ff @(posedge A1) begin
        if (figureLoad) begin
            dispWord <= wordNext;
        end
    end

endmodule

`default_nettype wire

/* hw/bcdConverter.sv */
`timescale 1ns/1ps
`default_nettype none

module bcdConverter
    import vendPkg::*;
(
    input  logic        A1,
    input  logic        A2,
    input  dispWordT    dispWord,
    input  logic        figureStrobe,
    output digitT [3:0] digits,
    output logic        negative,
    output logic        showPoint,
    output logic        digitsStrobe
);

    localparam int Steps = $bits(figureT);   // one shift per binary bit

    typedef enum logic {
        stIdle,
        stShift
    } convStateT;

    convStateT   state;
    logic [3:0]  stepCount;
    figureT      binReg;
    logic [15:0] bcdReg;
    logic [29:0] shifted;

    // add 3 to every digit of 5 or more before the shift doubles it
    function automatic logic [15:0] addThree(logic [15:0] b);
        logic [15:0] r;
        r = b;
        for (int i = 0; i < 4; i++) begin
            if (r[4*i +: 4] >= 4'd5) begin
                r[4*i +: 4] = r[4*i +: 4] + 4'd3;
            end
        end
        return r;
    endfunction

    assign shifted = {addThree(bcdReg), binReg} << 1;
    assign digits  = bcdReg;                                 // digit 0 in the low nibble

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            state        <= stIdle;
            stepCount    <= '0;
            digitsStrobe <= 1'b0;
        end else begin
            digitsStrobe <= 1'b0;
            if (figureStrobe) begin                          // newest figure restarts the run
                state     <= stShift;
                stepCount <= '0;
            end else if (state == stShift) begin
                stepCount <= stepCount + 4'd1;
                if (stepCount == 4'(Steps - 1)) begin       // last shift lands with the strobe
                    state        <= stIdle;
                    digitsStrobe <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge A1) begin
        if (figureStrobe) begin
            binReg    <= dispWord.figure;
            bcdReg    <= '0;
            negative  <= dispWord.negative;                  // flags ride along with the figure
            showPoint <= dispWord.showPoint;
        end else if (state == stShift) begin
            bcdReg <= shifted[29:14];
            binReg <= shifted[13:0];
        end
    end

endmodule

`default_nettype wire

/* hw/displayScanner.sv */
`timescale 1ns/1ps
`default_nettype none

module displayScanner
    import vendPkg::*;
#(
    parameter int ScanDivBits = 17
) (
    input  logic        A1,
    input  logic        A2,
    input  digitT [3:0] digits,
    input  logic        negative,
    input  logic        showPoint,
    input  logic        digitsStrobe,
    output logic [3:0]  anodes,
    output segT         segments
);

    segT                    codes [4];      // index 0 is the rightmost digit
    logic [ScanDivBits+1:0] scanCount;
    logic [1:0]             scanSel;

    // digits past 9 stay dark
    function automatic segT segOf(digitT d);
        if (d <= digitT'(9)) begin
            return SegDigits[d];
        end
        return 8'hFF;
    endfunction

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            for (int i = 0; i < 4; i++) begin
                codes[i] <= SegDigits[0];                   // 0000, no point
            end
        end else if (digitsStrobe) begin
            codes[0] <= segOf(digits[0]);
            codes[1] <= segOf(digits[1]);
            codes[2] <= segOf(digits[2]) & ~segT'(showPoint); // point is active low on bit 0
            if (negative) begin
                codes[3] <= SegMinus;                         // sign replaces thousands
            end else begin
                codes[3] <= segOf(digits[3]);
            end
        end
    end

    // free-running divider, top two bits pick the digit
    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    assign scanSel  = scanCount[ScanDivBits+1:ScanDivBits];
    assign anodes   = ~(4'b0001 << scanSel);                 // one low anode at a time
    assign segments = codes[scanSel];

endmodule

`default_nettype wire

/* hw/vendTop.sv */
`timescale 1ns/1ps
`default_nettype none

module vendTop
    import vendPkg::*;
#(
    // slot 8 (C3) first, slot 0 (A1) last
    parameter priceListT PriceList = {9'd375, 9'd325, 9'd100, 9'd250, 9'd225,
                                      9'd175, 9'd125, 9'd0, 9'd100},
    parameter moneyT     MaxCredit   = 9'd500,
    parameter int        ScanDivBits = 17
) (
    input  logic       A1,                  // system clock
    input  logic       A2,                  // async reset, active high
    input  coinT       coin,
    input  logic       selectStrobe,
    input  slotIdxT    slotIdx,
    input  logic       cancel,
    output slotLedsT   leds,
    output logic [3:0] anodes,
    output segT        segments
);

    moneyT               credit;
    moneyT               selPrice;
    logic [NumSlots-1:0] readyBits;
    logic [NumSlots-1:0] soldOutBits;
    logic [NumSlots-1:0] dispensedBits;
    dispWordT            dispWord;
    logic                figureStrobe;
    digitT [3:0]         digits;
    logic                negative;
    logic                showPoint;
    logic                digitsStrobe;

    assign leds = '{ready: readyBits, soldOut: soldOutBits, dispensed: dispensedBits};

    priceTable #(.PriceList(PriceList)) uPriceTable (
        .slotIdx(slotIdx), .credit(credit), .selPrice(selPrice),
        .ready(readyBits), .soldOut(soldOutBits)
    );

    creditLedger #(.MaxCredit(MaxCredit)) uLedger (
        .A1(A1), .A2(A2), .coin(coin), .selectStrobe(selectStrobe),
        .slotIdx(slotIdx), .cancel(cancel), .selPrice(selPrice), .credit(credit),
        .dispensed(dispensedBits), .dispWord(dispWord), .figureStrobe(figureStrobe)
    );

    bcdConverter uBcd (
        .A1(A1), .A2(A2), .dispWord(dispWord), .figureStrobe(figureStrobe),
        .digits(digits), .negative(negative), .showPoint(showPoint),
        .digitsStrobe(digitsStrobe)
    );

    displayScanner #(.ScanDivBits(ScanDivBits)) uScanner (
        .A1(A1), .A2(A2), .digits(digits), .negative(negative), .showPoint(showPoint),
        .digitsStrobe(digitsStrobe), .anodes(anodes), .segments(segments)
    );

endmodule

`default_nettype wire

/* tests/vendTb.sv */
`timescale 1ns/1ps
`default_nettype none

module vendTb
    import vendPkg::*;
();

    typedef enum logic [1:0] {
        actNone,
        actCoin,
        actSelect,
        actCancel
    } actionT;

    typedef segT [3:0] segRowT;                          // digit 3 is the leftmost

    typedef struct packed {
        actionT     action;
        logic [3:0] arg;                                 // coin code or slot index
        slotLedsT   leds;
        segRowT     segs;
    } rowT;

    localparam logic [15:0] Seed = 16'd56171;
    localparam int Prices [NumSlots] = '{100, 0, 125, 175, 225, 250, 100, 325, 375};
    localparam int CreditCap = 500;
    localparam int FillCoins = 8;                        // LFSR coins after the fixed rows

    logic        A1;
    logic        A2;
    coinT        coin;
    logic        selectStrobe;
    slotIdxT     slotIdx;
    logic        cancel;
    slotLedsT    leds;
    logic [3:0]  anodes;
    segT         segments;

    rowT         rows[$];
    string       rowNames[$];
    logic [15:0] lfsr;
    int          cycles = 0;
    int          cycleLimit = 0;                     // zero until the table is built

    vendTop #(.ScanDivBits(2)) i_dut (
        .A1(A1), .A2(A2), .coin(coin), .selectStrobe(selectStrobe), .slotIdx(slotIdx),
        .cancel(cancel), .leds(leds), .anodes(anodes), .segments(segments)
    );

    always #5 A1 = ~A1;                                  // 10 ns period

    always @(posedge A1) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            abortRun($sformatf("simulation timed out after %0d cycles", cycles));
        end
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    // ready and sold-out straight from the price list
    function automatic slotLedsT ledsFor(int credit, logic [NumSlots-1:0] given);
        slotLedsT l;
        l.dispensed = given;
        for (int i = 0; i < NumSlots; i++) begin
            l.soldOut[i] = (Prices[i] == 0);
            l.ready[i]   = (Prices[i] != 0) && (credit >= Prices[i]);
        end
        return l;
    endfunction

    function automatic segRowT segsFor(int figure, logic point, logic neg);
        segRowT s;
        s[0] = SegDigits[digitT'(figure % 10)];
        s[1] = SegDigits[digitT'((figure / 10) % 10)];
        s[2] = SegDigits[digitT'((figure / 100) % 10)];
        if (point) begin
            s[2][0] = 1'b0;                              // point is active low
        end
        s[3] = neg ? SegMinus : SegDigits[digitT'((figure / 1000) % 10)];
        return s;
    endfunction

    function automatic int centsOf(coinT c);
        case (c)
            coinNickel:  return 5;
            coinDime:    return 10;
            coinQuarter: return 25;
            coinDollar:  return 100;
            coinFive:    return 500;
            default:     return 0;
        endcase
    endfunction

    // taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawCoin(output coinT c);
        logic [2:0] pick;
        pick = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsrStep(lfsr);                       // one step per bit taken
            pick = {pick[1:0], lfsr[0]};
        end
        c = coinT'(3'd1 + (pick % 3'd5));                // nickel up to five
    endtask

    task automatic addRow(string name, actionT act, logic [3:0] arg, slotLedsT l, segRowT s);
        rowNames.push_back(name);
        rows.push_back('{action: act, arg: arg, leds: l, segs: s});
    endtask

    task automatic buildTable();
        int   credit;
        int   fig;
        logic pt;
        coinT c;
        addRow("reset state", actNone, 4'd0, ledsFor(0, '0), segsFor(0, 1'b0, 1'b0));
        addRow("price slot 3", actSelect, 4'd3, ledsFor(0, '0), segsFor(175, 1'b1, 1'b0));
        addRow("price slot 1", actSelect, 4'd1, ledsFor(0, '0), segsFor(0, 1'b1, 1'b0));
        addRow("coin dollar", actCoin, 4'(coinDollar), ledsFor(100, '0),
               segsFor(100, 1'b1, 1'b0));
        addRow("coin quarter", actCoin, 4'(coinQuarter), ledsFor(125, '0),
               segsFor(125, 1'b1, 1'b0));
        addRow("coin dime", actCoin, 4'(coinDime), ledsFor(135, '0), segsFor(135, 1'b1, 1'b0));
        addRow("five rejected", actCoin, 4'(coinFive), ledsFor(135, '0),
               segsFor(135, 1'b1, 1'b0));                // over the ceiling so the display holds
        addRow("shortfall slot 4", actSelect, 4'd4, ledsFor(135, '0), segsFor(90, 1'b1, 1'b1));
        addRow("buy slot 0", actSelect, 4'd0, ledsFor(0, 9'b000000001), segsFor(35, 1'b1, 1'b0));
        addRow("coin after buy", actCoin, 4'(coinNickel), ledsFor(5, 9'b000000001),
               segsFor(5, 1'b1, 1'b0));                  // credit restarts from zero
        addRow("cancel", actCancel, 4'd0, ledsFor(0, '0), segsFor(0, 1'b0, 1'b0));
        credit = 0;                                      // model starts from the cancel above
        fig = 0;
        pt = 1'b0;
        for (int n = 0; n < FillCoins; n++) begin
            drawCoin(c);
            if (credit + centsOf(c) <= CreditCap) begin
                credit = credit + centsOf(c);
                fig = credit;
                pt = 1'b1;
            end
            addRow($sformatf("fill coin %0d", n), actCoin, 4'(c), ledsFor(credit, '0),
                   segsFor(fig, pt, 1'b0));
        end
        addRow("final cancel", actCancel, 4'd0, ledsFor(0, '0), segsFor(0, 1'b0, 1'b0));
    endtask

    task automatic applyRow(rowT r);
        @(posedge A1);
        #1;
        case (r.action)
            actCoin:   coin = coinT'(r.arg[2:0]);
            actSelect: begin
                selectStrobe = 1'b1;
                slotIdx = slotIdxT'(r.arg);
            end
            actCancel: cancel = 1'b1;
            default:   ;                                 // just look at the current state
        endcase
        @(posedge A1);
        #1;
        coin = coinNone;                                 // strobes last one cycle
        selectStrobe = 1'b0;
        cancel = 1'b0;
    endtask

    // one full scan with segments filed under the active anode
    task automatic captureScan(string name, output segRowT seen);
        logic [3:0] hit;
        logic [1:0] sel;
        logic       found;
        hit = '0;
        seen = '1;
        repeat (16) begin
            @(posedge A1);
            #1;
            found = 1'b0;
            sel = '0;
            for (int d = 0; d < 4; d++) begin
                if (anodes == ~(4'b0001 << d)) begin
                    sel = 2'(d);
                    found = 1'b1;
                end
            end
            if (!found) begin
                abortRun($sformatf("%s: anodes %b do not select a single digit", name, anodes));
            end
            seen[sel] = segments;
            hit[sel] = 1'b1;
        end
        if (hit != 4'hF) begin
            abortRun($sformatf("%s: only digits %b were scanned", name, hit));
        end
    endtask

    task automatic checkLeds(string name, slotLedsT expected);
        if (leds !== expected) begin
            abortRun($sformatf("[ERROR] %s expected %h actual %h", name, expected, leds));
        end
    endtask

    task automatic checkSeg(string name, int digit, segT expected, segT actual);
        if (actual !== expected) begin
            abortRun($sformatf("[ERROR] %s digit %0d expected %b actual %b",
                               name, digit, expected, actual));
        end
    endtask

    initial begin
        segRowT seen;
        A1 = 1'b0;
        A2 = 1'b1;
        coin = coinNone;
        selectStrobe = 1'b0;
        slotIdx = '0;
        cancel = 1'b0;
        lfsr = Seed;
        buildTable();
        cycleLimit = rows.size() * 40 + 200;             // 38 cycles per row plus reset slack
        repeat (5) @(posedge A1);
        #1;
        A2 = 1'b0;
        foreach (rows[i]) begin
            applyRow(rows[i]);
            repeat (20) @(posedge A1);                   // figure reaches the scan within 17
            #1;
            checkLeds(rowNames[i], rows[i].leds);
            captureScan(rowNames[i], seen);
            for (int d = 0; d < 4; d++) begin
                checkSeg(rowNames[i], d, rows[i].segs[2'(d)], seen[2'(d)]);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/vendPkg.sv
hw/priceTable.sv
hw/creditLedger.sv
hw/bcdConverter.sv
hw/displayScanner.sv
hw/vendTop.sv
tests/vendTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile the vending controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module vendTb -o vendSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit $buildStatus
fi

./obj_dir/vendSim
simStatus=$?
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit $simStatus
fi
exit 0
